// File: testbench/link_fc_input.txt
20 0001 deadbeef
21 0002 00000001
22 0003 12345678
23 0004 a5a5a5a5
24 0005 5a5a5a5a
25 0006 ffffffff
26 0007 00000000
27 0008 0badf00d
28 0009 c0ffee00
29 000a 13572468
2a 000b 89abcdef
2b 000c fedcba98
2c 000d 0f0f0f0f
2d 000e f0f0f0f0
2e 000f 01020304
2f 0010 a0b0c0d0

// File: link_fc_top.f
source/link_fc_pkg.sv
source/sync_fifo.sv
source/link_trainer.sv
source/rx_seq_check.sv
source/tx_scheduler.sv
source/link_fc_top.sv
testbench/link_fc_props.sv
testbench/link_fc_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the loopback testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module link_fc_tb -f link_fc_top.f
status=0
out=$(./obj_dir/Vlink_fc_tb 2>&1) || status=$?
printf '%s\n' "$out"
test "$status" -eq 0
printf '%s\n' "$out" | grep -qx "Test passed"

// File: testbench/link_fc_tb.sv
// loopback testbench for the link flow control top level with file stimulus and final verdict
`timescale 1ns/1ps
`default_nettype none

module link_fc_tb;
  import link_fc_pkg::*;

  localparam int          TX_DEPTH   = DEF_TX_DEPTH;
  localparam int          RX_DEPTH   = DEF_RX_DEPTH;
  localparam int          SEED       = 52;
  localparam int          WAIT_LIMIT = 2000;
  localparam int          HOLD_WORDS = 10;
  localparam string       INPUT_FILE = "testbench/link_fc_input.txt";
  localparam logic [7:0]  CR_ID      = 8'h10;
  localparam logic [7:0]  CRACK_ID   = 8'h11;
  localparam logic [7:0]  ACK_ID     = 8'h12;

  typedef enum int {W_UP, W_DOWN, W_IDLE_TX, W_SENT, W_READ} wait_t;

  logic      link_clk = 1'b0;
  logic      link_reset;
  logic      enable;
  fc_ids_t   ids;
  logic      a2l_valid;
  logic      a2l_ready;
  app_word_t a2l_data;
  logic      l2a_valid;
  logic      l2a_accept = 1'b0;
  app_word_t l2a_data;
  logic      tx_fifo_empty;
  logic      rx_fifo_empty;
  logic      link_up;
  logic      rx_drop;
  link_pkt_t tx_pkt;
  logic      tx_advance = 1'b0;
  logic      rx_valid;
  logic      rx_crc_corrupted = 1'b0;

  app_word_t words[$];
  bit        hold_accept = 1'b0;
  bit        corrupt_armed = 1'b1;
  seq_t      exp_seq = '0;
  int        sent_data = 0;
  int        rx_count = 0;
  int        drop_count = 0;
  int        value_errs = 0;
  int        flow_errs = 0;
  int        step_errs = 0;

  always #5 link_clk = ~link_clk;

  // the link is looped straight back into the receive side
  assign rx_valid = tx_pkt.sop && tx_advance;

  link_fc_top #(.TX_DEPTH(TX_DEPTH), .RX_DEPTH(RX_DEPTH)) link_fc_top_i (
    .link_clk         (link_clk),
    .link_reset       (link_reset),
    .enable           (enable),
    .ids              (ids),
    .a2l_valid        (a2l_valid),
    .a2l_ready        (a2l_ready),
    .a2l_data         (a2l_data),
    .l2a_valid        (l2a_valid),
    .l2a_accept       (l2a_accept),
    .l2a_data         (l2a_data),
    .tx_fifo_empty    (tx_fifo_empty),
    .rx_fifo_empty    (rx_fifo_empty),
    .link_up          (link_up),
    .rx_drop          (rx_drop),
    .tx_pkt           (tx_pkt),
    .tx_advance       (tx_advance),
    .rx_pkt           (tx_pkt),
    .rx_valid         (rx_valid),
    .rx_crc_corrupted (rx_crc_corrupted)
  );

  task automatic check_word(input string name, input app_word_t got, input app_word_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_seq(input string name, input seq_t got, input seq_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      value_errs++;
    end
  endtask

  function automatic bit reached(input wait_t kind, input int target);
    case (kind)
      W_UP:      return link_up;
      W_DOWN:    return !link_up;
      W_IDLE_TX: return !tx_pkt.sop;
      W_SENT:    return sent_data >= target;
      default:   return rx_count >= target;
    endcase
  endfunction

  // polls on the falling edge, where the monitor counters are settled
  task automatic wait_until(input wait_t kind, input int target, input string what,
                            inout bit ok);
    int cycles;
    cycles = 0;
    if (ok) begin
      while (!reached(kind, target) && cycles < WAIT_LIMIT) begin
        @(negedge link_clk);
        cycles++;
      end
      if (!reached(kind, target)) begin
        $display("timeout while waiting for %s", what);
        step_errs++;
        ok = 1'b0;
      end
    end
  endtask

  task automatic push_word(input app_word_t w, inout bit ok);
    int cycles;
    cycles = 0;
    if (ok) begin
      @(posedge link_clk);
      a2l_valid <= 1'b1;
      a2l_data  <= w;
      @(posedge link_clk);
      while (!a2l_ready && cycles < WAIT_LIMIT) begin
        @(posedge link_clk);
        cycles++;
      end
      a2l_valid <= 1'b0;
      if (!a2l_ready) begin
        $display("timeout, the transmit queue never accepted a word");
        step_errs++;
        ok = 1'b0;
      end
    end
  endtask

  task automatic push_range(input int first, input int last, inout bit ok);
    for (int i = first; i < last && ok; i++) begin
      push_word(words[i], ok);
    end
  endtask

  // --------------------------------------------------------------------------
  // random link and application levels, loopback monitor
  // --------------------------------------------------------------------------
  always @(posedge link_clk) begin
    int outstanding;
    if (!link_reset) begin
      if (tx_pkt.sop && tx_advance) begin
        // first credit packet arrives corrupted and must be dropped
        if (corrupt_armed && tx_pkt.data_id == CR_ID) begin
          check_bit("rx_drop", rx_drop, 1'b1);
          corrupt_armed = 1'b0;
        end
        if (tx_pkt.data_id != CR_ID && tx_pkt.data_id != CRACK_ID &&
            tx_pkt.data_id != ACK_ID) begin
          check_seq("tx_pkt.seq", tx_pkt.seq, exp_seq);
          exp_seq = exp_seq + 8'd1;
          sent_data++;
        end
      end
      if (!link_up) begin
        exp_seq = '0;
      end
      if (rx_drop) begin
        drop_count++;
      end
      if (l2a_valid && l2a_accept) begin
        if (rx_count < words.size()) begin
          check_word("l2a_data", l2a_data, words[rx_count]);
        end else begin
          $display("a word was delivered beyond the end of the input file");
          flow_errs++;
        end
        rx_count++;
      end
      outstanding = sent_data - rx_count;
      if (outstanding > RX_DEPTH) begin
        $display("credit limit broken, %0d words in flight to the receive queue", outstanding);
        flow_errs++;
      end
    end
    tx_advance       <= ($urandom % 4) != 0;
    l2a_accept       <= !hold_accept && (($urandom % 2) == 0);
    rx_crc_corrupted <= corrupt_armed;
  end

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------
  initial begin
    bit          ok;
    int          fd;
    int          got;
    logic [7:0]  f_id;
    logic [15:0] f_wc;
    logic [31:0] f_pl;
    void'($urandom(SEED));
    link_reset = 1'b1;
    enable     = 1'b0;
    ids        = '{cr: CR_ID, crack: CRACK_ID, ack: ACK_ID};
    a2l_valid  = 1'b0;
    a2l_data   = '0;
    ok         = 1'b1;

    // each line holds data_id, word_count and payload in hex
    fd = $fopen(INPUT_FILE, "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file %s", INPUT_FILE);
      step_errs++;
      ok = 1'b0;
    end else begin
      got = 3;
      while (got == 3) begin
        got = $fscanf(fd, "%h %h %h\n", f_id, f_wc, f_pl);
        if (got == 3) begin
          words.push_back('{data_id: f_id, word_count: f_wc, payload: f_pl});
        end
      end
      $fclose(fd);
    end
    if (ok && words.size() <= HOLD_WORDS) begin
      $display("the stimulus file holds only %0d words", words.size());
      step_errs++;
      ok = 1'b0;
    end

    repeat (10) @(posedge link_clk);
    link_reset <= 1'b0;
    @(posedge link_clk);
    enable <= 1'b1;
    wait_until(W_UP, 0, "link_up after the first enable", ok);

    // far end reads nothing, so sending must stop at its depth
    @(negedge link_clk);
    hold_accept = 1'b1;
    push_range(0, HOLD_WORDS, ok);
    wait_until(W_SENT, RX_DEPTH, "data packets up to the credit limit", ok);
    repeat (40) @(negedge link_clk);
    if (ok && sent_data != RX_DEPTH) begin
      $display("sending did not stop at the credit limit, %0d packets went out", sent_data);
      step_errs++;
    end
    // words beyond the credit limit wait in the transmit queue
    if (ok) begin
      check_bit("tx_fifo_empty", tx_fifo_empty, 1'b0);
      check_bit("rx_fifo_empty", rx_fifo_empty, 1'b0);
    end
    hold_accept = 1'b0;
    wait_until(W_READ, HOLD_WORDS, "words after reading resumed", ok);

    // drop the link, then train again
    repeat (30) @(negedge link_clk);
    @(posedge link_clk);
    enable <= 1'b0;
    wait_until(W_DOWN, 0, "link_up to fall after disable", ok);
    wait_until(W_IDLE_TX, 0, "tx_pkt.sop to fall after disable", ok);
    @(posedge link_clk);
    enable <= 1'b1;
    wait_until(W_UP, 0, "link_up after the second enable", ok);
    push_range(HOLD_WORDS, words.size(), ok);
    wait_until(W_READ, words.size(), "the remaining words after retraining", ok);

    repeat (30) @(negedge link_clk);
    if (ok && rx_count != words.size()) begin
      $display("%0d words delivered for %0d in the file", rx_count, words.size());
      step_errs++;
    end
    if (ok && drop_count != 1) begin
      $display("rx_drop pulsed %0d times where one pulse was due", drop_count);
      step_errs++;
    end
    if (ok) begin
      check_bit("tx_fifo_empty", tx_fifo_empty, 1'b1);
      check_bit("rx_fifo_empty", rx_fifo_empty, 1'b1);
    end

    $display("errors: value %0d, flow %0d, step %0d", value_errs, flow_errs, step_errs);
    if (value_errs == 0 && flow_errs == 0 && step_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/link_fc_props.sv
// concurrent checks on the transmit packet hold and queue state, bound into the design
`timescale 1ns/1ps
`default_nettype none

module link_fc_props (
  input logic                   link_clk,
  input logic                   link_reset,
  input link_fc_pkg::link_pkt_t pkt,
  input logic                   advance,
  input logic                   wr_en,
  input logic                   ready,
  input logic                   empty
);

  // a packet waiting for the link keeps every field
  hold_while_stalled: assert property (@(posedge link_clk) disable iff (link_reset)
    !advance |=> $stable(pkt))
    else $error("tx_pkt changed while tx_advance was low");

  write_fills: assert property (@(posedge link_clk) disable iff (link_reset)
    (wr_en && ready) |=> !empty)
    else $error("queue still empty after an accepted write");

endmodule

// queue ports are tied quiet on the scheduler and the hold check is idle on the queues
bind tx_scheduler link_fc_props tx_hold_props (
  .link_clk   (link_clk),
  .link_reset (link_reset),
  .pkt        (tx_pkt),
  .advance    (tx_advance),
  .wr_en      (1'b0),
  .ready      (1'b1),
  .empty      (1'b1)
);

bind sync_fifo link_fc_props queue_props (
  .link_clk   (link_clk),
  .link_reset (link_reset),
  .pkt        ('0),
  .advance    (1'b1),
  .wr_en      (wr_en),
  .ready      (ready),
  .empty      (empty)
);

`default_nettype wire

// File: source/link_fc_top.sv
// flow control top level with transmit and receive queues, trainer, checker and scheduler
`timescale 1ns/1ps
`default_nettype none

module link_fc_top #(
  parameter int TX_DEPTH = link_fc_pkg::DEF_TX_DEPTH,
  parameter int RX_DEPTH = link_fc_pkg::DEF_RX_DEPTH
) (
  input  logic                   link_clk,
  input  logic                   link_reset,
  input  logic                   enable,
  input  link_fc_pkg::fc_ids_t   ids,
  input  logic                   a2l_valid,
  output logic                   a2l_ready,
  input  link_fc_pkg::app_word_t a2l_data,
  output logic                   l2a_valid,
  input  logic                   l2a_accept,
  output link_fc_pkg::app_word_t l2a_data,
  output logic                   tx_fifo_empty,
  output logic                   rx_fifo_empty,
  output logic                   link_up,
  output logic                   rx_drop,
  output link_fc_pkg::link_pkt_t tx_pkt,
  input  logic                   tx_advance,
  input  link_fc_pkg::link_pkt_t rx_pkt,
  input  logic                   rx_valid,
  input  logic                   rx_crc_corrupted
);
  import link_fc_pkg::*;

  app_word_t  q_data;
  app_word_t  rx_word;
  seq_t       last_good;
  logic       q_valid;
  logic       q_pop;
  logic       rx_wr;
  logic [7:0] rx_rd_count;
  logic [1:0] train_kind;
  logic [7:0] fe_credits;
  logic [7:0] fe_read;
  logic       tx_done;
  logic       cr_seen;
  logic       crack_seen;
  logic       ack_seen;
  logic       ack_pending;
  logic       ack_taken;

  // application to link
  sync_fifo #(.DEPTH(TX_DEPTH)) tx_queue (
    .link_clk   (link_clk),
    .link_reset (link_reset),
    .wr_en      (a2l_valid),
    .wr_data    (a2l_data),
    .ready      (a2l_ready),
    .rd_en      (q_pop),
    .rd_data    (q_data),
    .valid      (q_valid),
    .empty      (tx_fifo_empty),
    .rd_count   ()
  );

  // link to application, its read count feeds the ACKs
  sync_fifo #(.DEPTH(RX_DEPTH)) rx_queue (
    .link_clk   (link_clk),
    .link_reset (link_reset),
    .wr_en      (rx_wr),
    .wr_data    (rx_word),
    .ready      (),
    .rd_en      (l2a_accept),
    .rd_data    (l2a_data),
    .valid      (l2a_valid),
    .empty      (rx_fifo_empty),
    .rd_count   (rx_rd_count)
  );

  link_trainer link_trainer_i (
    .link_clk      (link_clk),
    .link_reset    (link_reset),
    .enable        (enable),
    .cr_seen       (cr_seen),
    .crack_seen    (crack_seen),
    .rx_word_count (rx_pkt.word_count),
    .tx_done       (tx_done),
    .train_kind    (train_kind),
    .link_up       (link_up),
    .fe_credits    (fe_credits)
  );

  rx_seq_check rx_seq_check_i (
    .link_clk         (link_clk),
    .link_reset       (link_reset),
    .link_up          (link_up),
    .ids              (ids),
    .rx_pkt           (rx_pkt),
    .rx_valid         (rx_valid),
    .rx_crc_corrupted (rx_crc_corrupted),
    .rd_count         (rx_rd_count),
    .ack_taken        (ack_taken),
    .rx_drop          (rx_drop),
    .cr_seen          (cr_seen),
    .crack_seen       (crack_seen),
    .ack_seen         (ack_seen),
    .fe_read          (fe_read),
    .rx_wr            (rx_wr),
    .rx_word          (rx_word),
    .ack_pending      (ack_pending),
    .last_good        (last_good)
  );

  tx_scheduler #(.RX_DEPTH(RX_DEPTH)) tx_scheduler_i (
    .link_clk    (link_clk),
    .link_reset  (link_reset),
    .ids         (ids),
    .train_kind  (train_kind),
    .link_up     (link_up),
    .fe_credits  (fe_credits),
    .ack_seen    (ack_seen),
    .fe_read     (fe_read),
    .ack_pending (ack_pending),
    .last_good   (last_good),
    .rd_count    (rx_rd_count),
    .q_valid     (q_valid),
    .q_data      (q_data),
    .q_pop       (q_pop),
    .ack_taken   (ack_taken),
    .tx_done     (tx_done),
    .tx_pkt      (tx_pkt),
    .tx_advance  (tx_advance)
  );

endmodule

`default_nettype wire

// File: source/tx_scheduler.sv
// transmit packet register with training, ACK and data priority and far end credit check
`timescale 1ns/1ps
`default_nettype none

module tx_scheduler #(
  parameter int RX_DEPTH = link_fc_pkg::DEF_RX_DEPTH
) (
  input  logic                   link_clk,
  input  logic                   link_reset,
  input  link_fc_pkg::fc_ids_t   ids,
  input  logic [1:0]             train_kind,
  input  logic                   link_up,
  input  logic [7:0]             fe_credits,
  input  logic                   ack_seen,
  input  logic [7:0]             fe_read,
  input  logic                   ack_pending,
  input  link_fc_pkg::seq_t      last_good,
  input  logic [7:0]             rd_count,
  input  logic                   q_valid,
  input  link_fc_pkg::app_word_t q_data,
  output logic                   q_pop,
  output logic                   ack_taken,
  output logic                   tx_done,
  output link_fc_pkg::link_pkt_t tx_pkt,
  input  logic                   tx_advance
);
  import link_fc_pkg::*;

  // own receive depth, announced in credit packets
  localparam logic [7:0] OWN_CREDITS = 8'(RX_DEPTH);

  link_pkt_t  pkt_nxt;
  logic [1:0] held_kind;
  logic [1:0] kind_nxt;
  seq_t       tx_seq;
  logic [7:0] sent_cnt;
  logic [7:0] fe_read_q;
  logic [7:0] outstanding;
  logic       credit_ok;
  logic       send_train;

  // sent_cnt and fe_read_q survive retraining, words left in the far end
  // queue still hold credits until they are read
  assign outstanding = sent_cnt - fe_read_q;
  assign credit_ok   = (outstanding < fe_credits);

  // --------------------------------------------------------------------------
  // selection, the register only moves when the link advances
  // --------------------------------------------------------------------------
  assign send_train = tx_advance && !link_up && (train_kind != TRAIN_NONE);
  assign ack_taken  = tx_advance && link_up && ack_pending;
  assign q_pop      = tx_advance && link_up && !ack_pending && q_valid && credit_ok;

  // only a training packet of the kind currently requested counts
  assign tx_done = tx_pkt.sop && tx_advance && (held_kind != TRAIN_NONE) &&
                   (held_kind == train_kind);

  always_comb begin
    pkt_nxt  = tx_pkt;
    kind_nxt = held_kind;
    if (tx_advance) begin
      pkt_nxt  = '0;
      kind_nxt = TRAIN_NONE;
      if (send_train) begin
        pkt_nxt.sop        = 1'b1;
        pkt_nxt.data_id    = (train_kind == TRAIN_CR) ? ids.cr : ids.crack;
        pkt_nxt.word_count = {8'd0, OWN_CREDITS};
        kind_nxt           = train_kind;
      end else if (ack_taken) begin
        pkt_nxt.sop        = 1'b1;
        pkt_nxt.data_id    = ids.ack;
        pkt_nxt.word_count = {rd_count, last_good};
      end else if (q_pop) begin
        pkt_nxt.sop        = 1'b1;
        pkt_nxt.data_id    = q_data.data_id;
        pkt_nxt.word_count = q_data.word_count;
        pkt_nxt.seq        = tx_seq;
        pkt_nxt.payload    = q_data.payload;
      end
    end
  end

  always_ff @(posedge link_clk or posedge link_reset) begin
    if (link_reset) begin
      tx_pkt    <= '0;
      held_kind <= TRAIN_NONE;
      tx_seq    <= '0;
      sent_cnt  <= 8'd0;
      fe_read_q <= 8'd0;
    end else begin
      tx_pkt    <= pkt_nxt;
      held_kind <= kind_nxt;
      // numbering restarts at 0 on every new link
      if (!link_up) begin
        tx_seq <= '0;
      end else if (q_pop) begin
        tx_seq <= tx_seq + 8'd1;
      end
      if (q_pop) begin
        sent_cnt <= sent_cnt + 8'd1;
      end
      if (ack_seen) begin
        fe_read_q <= fe_read;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/rx_seq_check.sv
// receive packet decoder, sequence number check and ACK request tracking
`timescale 1ns/1ps
`default_nettype none

module rx_seq_check (
  input  logic                   link_clk,
  input  logic                   link_reset,
  input  logic                   link_up,
  input  link_fc_pkg::fc_ids_t   ids,
  input  link_fc_pkg::link_pkt_t rx_pkt,
  input  logic                   rx_valid,
  input  logic                   rx_crc_corrupted,
  input  logic [7:0]             rd_count,
  input  logic                   ack_taken,
  output logic                   rx_drop,
  output logic                   cr_seen,
  output logic                   crack_seen,
  output logic                   ack_seen,
  output logic [7:0]             fe_read,
  output logic                   rx_wr,
  output link_fc_pkg::app_word_t rx_word,
  output logic                   ack_pending,
  output link_fc_pkg::seq_t      last_good
);
  import link_fc_pkg::*;

  logic       pkt_in;
  logic       pkt_ok;
  logic       is_data;
  logic       in_order;
  logic       rd_moved;
  seq_t       exp_seq;
  logic [7:0] rd_prev;

  assign pkt_in = rx_valid && rx_pkt.sop;
  assign pkt_ok = pkt_in && !rx_crc_corrupted;

  // --------------------------------------------------------------------------
  // classification
  // --------------------------------------------------------------------------
  assign cr_seen    = pkt_ok && (rx_pkt.data_id == ids.cr);
  assign crack_seen = pkt_ok && (rx_pkt.data_id == ids.crack);
  assign ack_seen   = pkt_ok && (rx_pkt.data_id == ids.ack);
  assign is_data    = pkt_ok && !cr_seen && !crack_seen && !ack_seen;

  // far end read count sits in the ACK high byte
  assign fe_read = rx_pkt.word_count[15:8];

  // data is only taken in order and while the link is up
  assign in_order = (rx_pkt.seq == exp_seq);
  assign rx_wr    = is_data && in_order && link_up;
  assign rx_drop  = (pkt_in && rx_crc_corrupted) || (is_data && !rx_wr);

  assign rx_word = '{data_id:    rx_pkt.data_id,
                     word_count: rx_pkt.word_count,
                     payload:    rx_pkt.payload};

  assign rd_moved = (rd_count != rd_prev);

  always_ff @(posedge link_clk or posedge link_reset) begin
    if (link_reset) begin
      exp_seq     <= '0;
      last_good   <= '0;
      ack_pending <= 1'b0;
      rd_prev     <= 8'd0;
    end else begin
      rd_prev <= rd_count;
      if (!link_up) begin
        exp_seq     <= '0;
        last_good   <= '0;
        ack_pending <= 1'b0;
      end else begin
        if (rx_wr) begin
          exp_seq   <= exp_seq + 8'd1;
          last_good <= rx_pkt.seq;
        end
        // a new good packet or read after the ACK was built needs another ACK
        ack_pending <= rx_wr || rd_moved || (ack_pending && !ack_taken);
      end
    end
  end

endmodule

`default_nettype wire

// File: source/link_trainer.sv
// enable synchronizer and credit exchange training FSM
`timescale 1ns/1ps
`default_nettype none

module link_trainer (
  input  logic        link_clk,
  input  logic        link_reset,
  input  logic        enable,
  input  logic        cr_seen,
  input  logic        crack_seen,
  input  logic [15:0] rx_word_count,
  input  logic        tx_done,
  output logic [1:0]  train_kind,
  output logic        link_up,
  output logic [7:0]  fe_credits
);
  import link_fc_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_SEND_CR, ST_SEND_CRACK, ST_UP} state_t;

  state_t state;
  state_t state_nxt;
  logic   en_meta;
  logic   en_sync;
  logic   cr_got;
  logic   crack_got;
  logic   training;

  assign training = (state == ST_SEND_CR) || (state == ST_SEND_CRACK);

  // --------------------------------------------------------------------------
  // state transitions
  // --------------------------------------------------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (en_sync) begin
          state_nxt = ST_SEND_CR;
        end
      end
      // far end credits must be known and one of ours must have gone out
      ST_SEND_CR: begin
        if ((cr_got || cr_seen) && tx_done) begin
          state_nxt = ST_SEND_CRACK;
        end
      end
      ST_SEND_CRACK: begin
        if ((crack_got || crack_seen) && tx_done) begin
          state_nxt = ST_UP;
        end
      end
      default: begin
        state_nxt = state;
      end
    endcase
    if (!en_sync) begin
      state_nxt = ST_IDLE;
    end
  end

  always_ff @(posedge link_clk or posedge link_reset) begin
    if (link_reset) begin
      en_meta    <= 1'b0;
      en_sync    <= 1'b0;
      state      <= ST_IDLE;
      cr_got     <= 1'b0;
      crack_got  <= 1'b0;
      fe_credits <= 8'd0;
    end else begin
      en_meta <= enable;
      en_sync <= en_meta;
      state   <= state_nxt;
      if (state_nxt == ST_IDLE) begin
        cr_got     <= 1'b0;
        crack_got  <= 1'b0;
        fe_credits <= 8'd0;
      end else begin
        // far end announces its receive depth in the low byte
        if (cr_seen && (state == ST_SEND_CR)) begin
          cr_got     <= 1'b1;
          fe_credits <= rx_word_count[7:0];
        end
        if (crack_seen && training) begin
          crack_got <= 1'b1;
        end
      end
    end
  end

  assign link_up    = (state == ST_UP);
  assign train_kind = (state == ST_SEND_CR)    ? TRAIN_CR :
                      (state == ST_SEND_CRACK) ? TRAIN_CRACK : TRAIN_NONE;

endmodule

`default_nettype wire

// File: source/sync_fifo.sv
// synchronous register-array queue of application words with a wrapping read counter
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int DEPTH = link_fc_pkg::DEF_TX_DEPTH
) (
  input  logic                   link_clk,
  input  logic                   link_reset,
  input  logic                   wr_en,
  input  link_fc_pkg::app_word_t wr_data,
  output logic                   ready,
  input  logic                   rd_en,
  output link_fc_pkg::app_word_t rd_data,
  output logic                   valid,
  output logic                   empty,
  output logic [7:0]             rd_count
);
  import link_fc_pkg::*;

  localparam int AW = $clog2(DEPTH);

  app_word_t   mem [DEPTH];
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        full;
  logic        do_wr;
  logic        do_rd;

  // extra pointer bit tells full from empty
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign ready = !full;
  assign valid = !empty;

  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  assign rd_data = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge link_clk) begin
    if (do_wr) begin
      mem[wr_ptr[AW-1:0]] <= wr_data;
    end
  end

  // rd_count wraps at 256 and is reported to the far end in ACKs
  always_ff @(posedge link_clk or posedge link_reset) begin
    if (link_reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      rd_count <= 8'd0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr   <= rd_ptr + 1'b1;
        rd_count <= rd_count + 8'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/link_fc_pkg.sv
// shared types, training request codes and default queue depths for the link flow control
`default_nettype none

package link_fc_pkg;

  // packet sequence number, wraps modulo 256
  typedef logic [7:0] seq_t;

  // one application word as it enters and leaves the queues
  typedef struct packed {
    logic [7:0]  data_id;
    logic [15:0] word_count;
    logic [31:0] payload;
  } app_word_t;

  // one packet on the link, sop marks a packet as present
  typedef struct packed {
    logic        sop;
    logic [7:0]  data_id;
    logic [15:0] word_count;
    seq_t        seq;
    logic [31:0] payload;
  } link_pkt_t;

  // data ids assigned by software for the control packets
  typedef struct packed {
    logic [7:0] cr;
    logic [7:0] crack;
    logic [7:0] ack;
  } fc_ids_t;

  // training packet request from the trainer to the scheduler
  localparam logic [1:0] TRAIN_NONE  = 2'd0;
  localparam logic [1:0] TRAIN_CR    = 2'd1;
  localparam logic [1:0] TRAIN_CRACK = 2'd2;

  // queue depths, any power of two from 2 to 128
  localparam int DEF_TX_DEPTH = 8;
  localparam int DEF_RX_DEPTH = 8;

endpackage

`default_nettype wire
